/* cgra_defs.svh */
`ifndef CGRA_DEFS_SVH
`define CGRA_DEFS_SVH

// target codes, upper half of config_addr
`define CFG_TARGET_SB  16'd7
`define CFG_TARGET_CB0 16'd6
`define CFG_TARGET_CB1 16'd5
`define CFG_TARGET_CLB 16'd4

// bus widths
`define CFG_W 32
`define ID_W  16

// tile shape
`define SIDES     4
`define TRACKS    4 // per side
`define CB_TRACKS 8 // 4 inputs + 4 switch box outputs

// configuration field widths
`define ROUTE_W  2
`define CB_SEL_W 3
`define CLB_OP_W 2

`endif

/* cgra_pkg.sv */
`default_nettype none

`include "cgra_defs.svh"

package cgra_pkg;

	// logic block function
	typedef enum logic [`CLB_OP_W-1:0] {
		op_and  = 2'd0,
		op_or   = 2'd1,
		op_xor  = 2'd2,
		op_nand = 2'd3
	} clb_op_e;

	// source for one outgoing track, side s
	typedef enum logic [`ROUTE_W-1:0] {
		route_next     = 2'd0, // side s+1
		route_opposite = 2'd1, // side s+2
		route_prev     = 2'd2, // side s+3
		route_pe       = 2'd3  // registered logic block result
	} route_sel_e;

	// one config_data word, decoded per target
	typedef union packed {
		route_sel_e [`SIDES-1:0][`TRACKS-1:0] sb_view; // [side][track], side 0 lowest byte
		struct packed {
			logic [`CFG_W-`CB_SEL_W-1:0] pad;
			logic [`CB_SEL_W-1:0]        sel;
		} cb_view;
		struct packed {
			logic [`CFG_W-`CLB_OP_W-1:0] pad;
			clb_op_e                     op;
		} clb_view;
	} cfg_word_u;

endpackage

`default_nettype wire

/* tile_config_decode.sv */
`default_nettype none

`include "cgra_defs.svh"

module tile_config_decode (
	input  wire [`CFG_W-1:0] config_addr,
	input  wire [`ID_W-1:0]  tile_id,
	output logic             sb_cfg_en,
	output logic             cb0_cfg_en,
	output logic             cb1_cfg_en,
	output logic             clb_cfg_en
);

	logic            id_hit;
	logic [`ID_W-1:0] target;

	assign id_hit = (config_addr[`ID_W-1:0] == tile_id);
	assign target = config_addr[`CFG_W-1:`ID_W];

	// one hot or idle; an unknown target is simply ignored
	always_comb begin
		sb_cfg_en  = 1'b0;
		cb0_cfg_en = 1'b0;
		cb1_cfg_en = 1'b0;
		clb_cfg_en = 1'b0;
		if (id_hit) begin
			case (target)
				`CFG_TARGET_SB: begin
					sb_cfg_en = 1'b1;
				end
				`CFG_TARGET_CB0: begin
					cb0_cfg_en = 1'b1;
				end
				`CFG_TARGET_CB1: begin
					cb1_cfg_en = 1'b1;
				end
				`CFG_TARGET_CLB: begin
					clb_cfg_en = 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* connect_box.sv */
`default_nettype none

`include "cgra_defs.svh"

module connect_box (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   config_en,
	input  cgra_pkg::cfg_word_u   config_data,
	input  wire [`CB_TRACKS-1:0]  track_in,
	output logic                  block_out
);

	// track select, 0..3 tile inputs, 4..7 switch box outputs
	logic [`CB_SEL_W-1:0] sel_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_q <= '0; // track 0
		end else if (config_en) begin
			sel_q <= config_data.cb_view.sel;
		end
	end

	always_comb begin
		block_out = track_in[sel_q];
	end

endmodule

`default_nettype wire

/* clb.sv */
`default_nettype none

`include "cgra_defs.svh"

module clb (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 config_enable,
	input  cgra_pkg::cfg_word_u config_data,
	input  wire                 in0,
	input  wire                 in1,
	output logic                out
);

	import cgra_pkg::*;

	clb_op_e op_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			op_q <= op_and;
		end else if (config_enable) begin
			op_q <= config_data.clb_view.op;
		end
	end

	// result register sits in the switch box
	always_comb begin
		case (op_q)
			op_and: begin
				out = in0 & in1;
			end
			op_or: begin
				out = in0 | in1;
			end
			op_xor: begin
				out = in0 ^ in1;
			end
			default: begin
				out = ~(in0 & in1); // nand
			end
		endcase
	end

endmodule

`default_nettype wire

/* switch_box_bottom_left.sv */
`default_nettype none

`include "cgra_defs.svh"

module switch_box_bottom_left (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 config_en,
	input  cgra_pkg::cfg_word_u config_data,
	input  wire [`TRACKS-1:0]   in_wire_0,
	input  wire [`TRACKS-1:0]   in_wire_1,
	input  wire [`TRACKS-1:0]   in_wire_2,
	input  wire [`TRACKS-1:0]   in_wire_3,
	input  wire                 pe_output,
	output logic [`TRACKS-1:0]  out_wire_0,
	output logic [`TRACKS-1:0]  out_wire_1,
	output logic [`TRACKS-1:0]  out_wire_3
);

	import cgra_pkg::*;

	// [side][track]; side 2 is kept but has no outputs on this tile
	route_sel_e [`SIDES-1:0][`TRACKS-1:0] route_q;
	logic                                 pe_reg;

	// one side worth of tracks, each track picks from its own field
	function automatic logic [`TRACKS-1:0] route_side(
		input route_sel_e [`TRACKS-1:0] sel,
		input logic [`TRACKS-1:0]       from_next,
		input logic [`TRACKS-1:0]       from_opp,
		input logic [`TRACKS-1:0]       from_prev,
		input logic                     from_pe
	);
		logic [`TRACKS-1:0] res;
		res = '0;
		for (int t = 0; t < `TRACKS; t++) begin
			case (sel[t])
				route_next: begin
					res[t] = from_next[t];
				end
				route_opposite: begin
					res[t] = from_opp[t];
				end
				route_prev: begin
					res[t] = from_prev[t];
				end
				default: begin
					res[t] = from_pe; // route_pe
				end
			endcase
		end
		return res;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			route_q <= '0; // all route_next
		end else if (config_en) begin
			route_q <= config_data.sb_view;
		end
	end

	// logic block result, one cycle late on every pe route
	always_ff @(posedge clk) begin
		if (rst) begin
			pe_reg <= 1'b0;
		end else begin
			pe_reg <= pe_output;
		end
	end

	// next / opposite / prev are side s+1, s+2, s+3 mod 4
	always_comb begin
		out_wire_0 = route_side(route_q[0], in_wire_1, in_wire_2, in_wire_3, pe_reg);
		out_wire_1 = route_side(route_q[1], in_wire_2, in_wire_3, in_wire_0, pe_reg);
		out_wire_3 = route_side(route_q[3], in_wire_0, in_wire_1, in_wire_2, pe_reg);
	end

endmodule

`default_nettype wire

/* pe_tile_bottom_left.sv */
`default_nettype none

module pe_tile_bottom_left (
	input  wire        clk,
	input  wire        rst,
	input  wire [31:0] config_addr,
	input  wire [31:0] config_data,
	input  wire [15:0] tile_id,
	input  wire [3:0]  in_wire_0,
	input  wire [3:0]  in_wire_1,
	input  wire [3:0]  in_wire_2,
	input  wire [3:0]  in_wire_3,
	output logic [3:0] out_wire_0,
	output logic       out_wire_1_0,
	output logic [3:0] out_wire_3
);

	logic       sb_cfg_en;
	logic       cb0_cfg_en;
	logic       cb1_cfg_en;
	logic       clb_cfg_en;

	logic       op_0;
	logic       op_1;
	logic       pe_output;

	// side 1 outputs, only track 0 leaves the tile
	logic [3:0] out_wire_1;

	assign out_wire_1_0 = out_wire_1[0];

	tile_config_decode decode (
		.config_addr (config_addr),
		.tile_id     (tile_id),
		.sb_cfg_en   (sb_cfg_en),
		.cb0_cfg_en  (cb0_cfg_en),
		.cb1_cfg_en  (cb1_cfg_en),
		.clb_cfg_en  (clb_cfg_en)
	);

	// upper four tracks come back from the switch box
	connect_box cb0 (
		.clk         (clk),
		.rst         (rst),
		.config_en   (cb0_cfg_en),
		.config_data (config_data),
		.track_in    ({out_wire_0, in_wire_0}),
		.block_out   (op_0)
	);

	connect_box cb1 (
		.clk         (clk),
		.rst         (rst),
		.config_en   (cb1_cfg_en),
		.config_data (config_data),
		.track_in    ({out_wire_1, in_wire_1}),
		.block_out   (op_1)
	);

	switch_box_bottom_left sb (
		.clk         (clk),
		.rst         (rst),
		.config_en   (sb_cfg_en),
		.config_data (config_data),
		.in_wire_0   (in_wire_0),
		.in_wire_1   (in_wire_1),
		.in_wire_2   (in_wire_2),
		.in_wire_3   (in_wire_3),
		.pe_output   (pe_output),
		.out_wire_0  (out_wire_0),
		.out_wire_1  (out_wire_1),
		.out_wire_3  (out_wire_3)
	);

	clb compute_block (
		.clk           (clk),
		.rst           (rst),
		.config_enable (clb_cfg_en),
		.config_data   (config_data),
		.in0           (op_0),
		.in1           (op_1),
		.out           (pe_output) // registered inside sb
	);

endmodule

`default_nettype wire

/* pe_tile_assert.sv */
`default_nettype none

module pe_tile_assert (
	input wire        clk,
	input wire        rst,
	input wire        sb_cfg_en,
	input wire        cb0_cfg_en,
	input wire        cb1_cfg_en,
	input wire        clb_cfg_en,
	input wire [31:0] sb_route,
	input wire [2:0]  cb0_sel,
	input wire [2:0]  cb1_sel,
	input wire [1:0]  clb_op
);

	a_one_enable: assert property (@(posedge clk)
		$onehot0({sb_cfg_en, cb0_cfg_en, cb1_cfg_en, clb_cfg_en}))
		else $error("more than one configuration enable high");

	// all config registers cleared right after reset
	a_reset_clear: assert property (@(posedge clk)
		rst |=> (sb_route == '0 && cb0_sel == '0 && cb1_sel == '0 && clb_op == '0))
		else $error("configuration not cleared by reset");

	a_sb_hold: assert property (@(posedge clk) disable iff (rst)
		!sb_cfg_en |=> $stable(sb_route))
		else $error("switch box routes changed without enable");

	a_cb0_hold: assert property (@(posedge clk) disable iff (rst)
		!cb0_cfg_en |=> $stable(cb0_sel))
		else $error("connect box 0 select changed without enable");

	a_cb1_hold: assert property (@(posedge clk) disable iff (rst)
		!cb1_cfg_en |=> $stable(cb1_sel))
		else $error("connect box 1 select changed without enable");

	a_clb_hold: assert property (@(posedge clk) disable iff (rst)
		!clb_cfg_en |=> $stable(clb_op))
		else $error("logic block op changed without enable");

endmodule

bind pe_tile_bottom_left pe_tile_assert tile_checks (
	.clk        (clk),
	.rst        (rst),
	.sb_cfg_en  (sb_cfg_en),
	.cb0_cfg_en (cb0_cfg_en),
	.cb1_cfg_en (cb1_cfg_en),
	.clb_cfg_en (clb_cfg_en),
	.sb_route   (sb.route_q),
	.cb0_sel    (cb0.sel_q),
	.cb1_sel    (cb1.sel_q),
	.clb_op     (compute_block.op_q)
);

`default_nettype wire

/* pe_tile_tb.sv */
`default_nettype none

`include "cgra_defs.svh"

module pe_tile_tb;

	import cgra_pkg::*;

	localparam logic [15:0] own_id     = 16'h0025;
	localparam logic [31:0] idle_addr  = 32'h0000_0000; // id 0 is never this tile
	localparam int          max_cycles = 2000;

	logic        clk;
	logic        rst;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	logic [15:0] tile_id;
	logic [3:0]  in_wire_0;
	logic [3:0]  in_wire_1;
	logic [3:0]  in_wire_2;
	logic [3:0]  in_wire_3;
	logic [3:0]  out_wire_0;
	logic        out_wire_1_0;
	logic [3:0]  out_wire_3;

	integer      seed;
	logic [31:0] rnd;
	int          errors = 0;
	int          cycles = 0;

	// expected configuration state of the tile
	logic [31:0] sb_shadow;
	logic [2:0]  cb0_shadow;
	logic [2:0]  cb1_shadow;
	logic [1:0]  clb_shadow;
	logic        pe_model;
	logic [9:0]  exp_vec;

	pe_tile_bottom_left dut0 (
		.clk          (clk),
		.rst          (rst),
		.config_addr  (config_addr),
		.config_data  (config_data),
		.tile_id      (tile_id),
		.in_wire_0    (in_wire_0),
		.in_wire_1    (in_wire_1),
		.in_wire_2    (in_wire_2),
		.in_wire_3    (in_wire_3),
		.out_wire_0   (out_wire_0),
		.out_wire_1_0 (out_wire_1_0),
		.out_wire_3   (out_wire_3)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// returns {next pe value, out_wire_3, out_wire_1_0, out_wire_0}
	function automatic logic [9:0] expected_outputs(
		input logic [31:0] sb_word,
		input logic [2:0]  sel0,
		input logic [2:0]  sel1,
		input logic [1:0]  op,
		input logic [3:0]  w0,
		input logic [3:0]  w1,
		input logic [3:0]  w2,
		input logic [3:0]  w3,
		input logic        pe_q
	);
		logic [3:0] side_in [4];
		logic [3:0] side_out [4];
		logic [7:0] tracks0;
		logic [7:0] tracks1;
		logic       a;
		logic       b;
		logic       r;
		route_sel_e code;
		side_in[0] = w0;
		side_in[1] = w1;
		side_in[2] = w2;
		side_in[3] = w3;
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				code = route_sel_e'(sb_word[(s * 4 + t) * 2 +: 2]);
				case (code)
					route_next:     side_out[s][t] = side_in[(s + 1) % 4][t];
					route_opposite: side_out[s][t] = side_in[(s + 2) % 4][t];
					route_prev:     side_out[s][t] = side_in[(s + 3) % 4][t];
					default:        side_out[s][t] = pe_q;
				endcase
			end
		end
		tracks0 = {side_out[0], side_in[0]}; // upper half from the switch box
		tracks1 = {side_out[1], side_in[1]};
		a = tracks0[sel0];
		b = tracks1[sel1];
		case (clb_op_e'(op))
			op_and:  r = a & b;
			op_or:   r = a | b;
			op_xor:  r = a ^ b;
			default: r = ~(a & b);
		endcase
		return {r, side_out[3], side_out[1][0], side_out[0]};
	endfunction

	task automatic step(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] r;
		r = $random(seed);
		config_addr = addr;
		config_data = data;
		in_wire_0 = r[3:0];
		in_wire_1 = r[7:4];
		in_wire_2 = r[11:8];
		in_wire_3 = r[15:12];
		@(posedge clk);
		#1;
	endtask

	task automatic write_cfg(input logic [15:0] target, input logic [15:0] id,
		input logic [31:0] data);
		step({target, id}, data);
	endtask

	task automatic run_random(input int n);
		logic [31:0] r;
		repeat (n) begin
			r = $random(seed);
			step(idle_addr, r); // data alone must not write
		end
	endtask

	// compare just before each rising edge
	always @(posedge clk) begin
		#3;
		if (rst) begin
			sb_shadow = '0;
			cb0_shadow = '0;
			cb1_shadow = '0;
			clb_shadow = '0;
			pe_model = 1'b0;
		end else begin
			exp_vec = expected_outputs(sb_shadow, cb0_shadow, cb1_shadow, clb_shadow,
				in_wire_0, in_wire_1, in_wire_2, in_wire_3, pe_model);
			if (out_wire_0 !== exp_vec[3:0]) begin
				$display("** Error: out_wire_0 expected %h got %h at %0t",
					exp_vec[3:0], out_wire_0, $time);
				errors++;
			end
			if (out_wire_1_0 !== exp_vec[4]) begin
				$display("** Error: out_wire_1_0 expected %h got %h at %0t",
					exp_vec[4], out_wire_1_0, $time);
				errors++;
			end
			if (out_wire_3 !== exp_vec[8:5]) begin
				$display("** Error: out_wire_3 expected %h got %h at %0t",
					exp_vec[8:5], out_wire_3, $time);
				errors++;
			end
			pe_model = exp_vec[9]; // taken into pe_reg at the coming edge
			if (config_addr[15:0] == own_id) begin
				case (config_addr[31:16])
					`CFG_TARGET_SB:  sb_shadow = config_data;
					`CFG_TARGET_CB0: cb0_shadow = config_data[2:0];
					`CFG_TARGET_CB1: cb1_shadow = config_data[2:0];
					`CFG_TARGET_CLB: clb_shadow = config_data[1:0];
					default: ;
				endcase
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: tests still running after %0d clock cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		seed = 32'h0cca_4333;
		rst = 1'b1;
		config_addr = idle_addr;
		config_data = '0;
		tile_id = own_id;
		in_wire_0 = '0;
		in_wire_1 = '0;
		in_wire_2 = '0;
		in_wire_3 = '0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// reset config routes every output from the next side
		run_random(30);

		// foreign ids and unused targets while pe is routed out
		write_cfg(`CFG_TARGET_SB, own_id, 32'h3000_0303);
		run_random(4);
		write_cfg(`CFG_TARGET_SB, 16'h0026, 32'hffff_ffff);
		write_cfg(`CFG_TARGET_CB0, 16'h2500, 32'hffff_ffff);
		write_cfg(`CFG_TARGET_CB1, 16'h0024, 32'hffff_ffff);
		write_cfg(`CFG_TARGET_CLB, 16'h0000, 32'hffff_ffff);
		run_random(4);
		write_cfg(16'd0, own_id, 32'hffff_ffff);
		write_cfg(16'd3, own_id, 32'hffff_ffff);
		write_cfg(16'd8, own_id, 32'hffff_ffff);
		write_cfg(16'hffff, own_id, 32'hffff_ffff);
		run_random(4);

		repeat (15) begin
			rnd = $random(seed);
			write_cfg(`CFG_TARGET_SB, own_id, rnd);
			run_random(8);
		end

		// a few outputs forced to pe so the logic block is visible
		for (int op = 0; op < 4; op++) begin
			rnd = $random(seed);
			write_cfg(`CFG_TARGET_SB, own_id, rnd | 32'h3000_0303);
			write_cfg(`CFG_TARGET_CLB, own_id, op);
			for (int sel = 0; sel < 8; sel++) begin
				write_cfg(`CFG_TARGET_CB0, own_id, sel);
				write_cfg(`CFG_TARGET_CB1, own_id, (sel + 3) % 8);
				run_random(4);
			end
		end

		// one target at a time while the rest stays in force
		repeat (20) begin
			rnd = $random(seed);
			case (rnd[17:16])
				2'd0: write_cfg(`CFG_TARGET_SB, own_id, rnd);
				2'd1: write_cfg(`CFG_TARGET_CB0, own_id, rnd);
				2'd2: write_cfg(`CFG_TARGET_CB1, own_id, rnd);
				default: write_cfg(`CFG_TARGET_CLB, own_id, rnd);
			endcase
			run_random(4);
		end

		run_random(2);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
cgra_pkg.sv
tile_config_decode.sv
connect_box.sv
clb.sv
switch_box_bottom_left.sv
pe_tile_bottom_left.sv
pe_tile_assert.sv
pe_tile_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= pe_tile_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
